// File: filelist.f
+incdir+testbench
verilog/muldiv_op_pkg.sv
verilog/muldiv_ctrl_pkg.sv
verilog/muldiv_decode.sv
verilog/muldiv_ctrl.sv
verilog/booth_mul_dpath.sv
verilog/nonrestoring_div_dpath.sv
verilog/muldiv_top.sv
testbench/muldiv_tb.sv

// File: testbench/muldiv_ref.svh
// Reference model for the eight RISC-V M-extension operations

`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// Expected 32-bit result of one operation, special divides included
function automatic logic [31:0] muldiv_ref(input muldiv_op_pkg::op_e op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] ub_s;
  logic [63:0]        ua;
  logic [63:0]        ub;
  logic [63:0]        prod;
  logic               div_zero;
  logic               div_ovf;
  sa       = {{32{a[31]}}, a};
  sb       = {{32{b[31]}}, b};
  ua       = {32'b0, a};
  ub       = {32'b0, b};
  ub_s     = {32'b0, b};
  div_zero = (b == 32'h0);
  // Most negative over minus one
  div_ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  case (op)
    muldiv_op_pkg::MUL:    prod = ua * ub;
    muldiv_op_pkg::MULH:   prod = sa * sb;
    muldiv_op_pkg::MULHSU: prod = sa * ub_s;
    default:               prod = ua * ub;
  endcase
  case (op)
    muldiv_op_pkg::MUL:    return prod[31:0];
    muldiv_op_pkg::MULH,
    muldiv_op_pkg::MULHSU,
    muldiv_op_pkg::MULHU:  return prod[63:32];
    // Quotient rounds toward zero
    muldiv_op_pkg::DIV: begin
      if (div_zero) begin
        return 32'hffff_ffff;
      end else if (div_ovf) begin
        return a;
      end else begin
        return $signed(a) / $signed(b);
      end
    end
    muldiv_op_pkg::DIVU:   return div_zero ? 32'hffff_ffff : a / b;
    // Remainder takes the dividend's sign
    muldiv_op_pkg::REM: begin
      if (div_zero) begin
        return a;
      end else if (div_ovf) begin
        return 32'h0;
      end else begin
        return $signed(a) % $signed(b);
      end
    end
    default:               return div_zero ? a : a % b;
  endcase
endfunction

`endif

// File: testbench/muldiv_tb.sv
// Testbench for the multiply/divide unit with reference compare and stall checks

`timescale 1ns/10ps

module muldiv_tb;

  `include "muldiv_ref.svh"

  localparam int TIMEOUT = 100;

  logic               clk;
  logic               i_reset;
  logic               i_req_valid;
  muldiv_op_pkg::op_e i_op;
  logic [31:0]        i_rs1;
  logic [31:0]        i_rs2;
  logic               o_req_ready;
  logic               o_result_valid;
  logic [31:0]        o_result;
  logic               i_result_ready;
  int                 errors;
  int                 checks;

  muldiv_top #(.XLEN(muldiv_op_pkg::XLEN_DEFAULT)) uut (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_req_valid    (i_req_valid),
    .i_op           (i_op),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .o_req_ready    (o_req_ready),
    .o_result_valid (o_result_valid),
    .o_result       (o_result),
    .i_result_ready (i_result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Compare one value and log a mismatch
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // One request, optional stall of the result, retire
  // exp_lat below zero skips the latency check
  task automatic run_op(input muldiv_op_pkg::op_e op, input logic [31:0] a,
                        input logic [31:0] b, input int stall, input int exp_lat);
    logic [31:0] expected;
    logic [31:0] held;
    int          cycles;
    int          i;
    expected = muldiv_ref(op, a, b);
    @(posedge clk);
    i_req_valid    <= 1'b1;
    i_op           <= op;
    i_rs1          <= a;
    i_rs2          <= b;
    i_result_ready <= (stall == 0);
    cycles = 0;
    // Outputs sampled mid-cycle
    @(negedge clk);
    while (!o_result_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_result_valid) begin
      errors++;
      $display("Timeout: %s gave no result within %0d cycles", op.name(), TIMEOUT);
    end else begin
      if (exp_lat >= 0) begin
        check_value("o_result_valid latency", cycles, exp_lat);
      end
      check_value("o_result", o_result, expected);
      held = o_result;
      // Result must hold while downstream is not ready
      for (i = 0; i < stall; i++) begin
        check_value("o_req_ready", o_req_ready, 1'b0);
        @(posedge clk);
        if (i == stall - 1) begin
          i_result_ready <= 1'b1;
        end
        @(negedge clk);
        check_value("o_result_valid", o_result_valid, 1'b1);
        check_value("o_result", o_result, held);
      end
      check_value("o_req_ready", o_req_ready, 1'b1);
    end
    // Retire edge
    @(posedge clk);
    i_req_valid    <= 1'b0;
    i_result_ready <= 1'b0;
  endtask

  initial begin
    int                 k;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        q;
    muldiv_op_pkg::op_e op;
    void'($urandom(40));
    errors         = 0;
    checks         = 0;
    i_reset        <= 1'b1;
    i_req_valid    <= 1'b0;
    i_op           <= muldiv_op_pkg::MUL;
    i_rs1          <= '0;
    i_rs2          <= '0;
    i_result_ready <= 1'b0;
    repeat (10) @(posedge clk);
    i_reset <= 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Idle after reset
    ////////////////////////////////////////////////////////////////////////////
    repeat (5) begin
      @(negedge clk);
      check_value("o_result_valid", o_result_valid, 1'b0);
    end

    // Multiply family, fixed 16-cycle latency
    for (k = 0; k < 40; k++) begin
      op = muldiv_op_pkg::op_e'(k % 4);
      run_op(op, $urandom, $urandom, 0, 16);
    end
    run_op(muldiv_op_pkg::MULH, 32'h8000_0000, 32'h8000_0000, 0, 16);
    run_op(muldiv_op_pkg::MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0, 16);
    run_op(muldiv_op_pkg::MULHU, 32'hffff_ffff, 32'hffff_ffff, 0, 16);

    ////////////////////////////////////////////////////////////////////////////
    // Divide family
    ////////////////////////////////////////////////////////////////////////////
    for (k = 0; k < 40; k++) begin
      op = muldiv_op_pkg::op_e'(4 + k % 4);
      a  = $urandom;
      b  = $urandom;
      // Half of them with a short divisor of either sign
      if (k % 2) begin
        b = b >> $urandom_range(8, 28);
        if ($urandom_range(0, 1)) b = -b;
      end
      if (b == 32'h0) b = 32'h1;
      run_op(op, a, b, 0, -1);
    end
    // Exact quotients drive the correction path
    for (k = 0; k < 24; k++) begin
      op = muldiv_op_pkg::op_e'(4 + k % 4);
      q  = $urandom_range(1, 65535);
      b  = $urandom_range(1, 32767);
      if ($urandom_range(0, 1)) q = -q;
      if ($urandom_range(0, 1)) b = -b;
      a  = q * b;
      run_op(op, a, b, 0, -1);
    end
    run_op(muldiv_op_pkg::DIV, 32'h0, 32'h7, 0, -1);
    run_op(muldiv_op_pkg::DIVU, 32'h8000_0000, 32'hffff_ffff, 0, -1);

    // Divide by zero and signed overflow, same-cycle result
    for (k = 0; k < 4; k++) begin
      run_op(muldiv_op_pkg::op_e'(4 + k), $urandom, 32'h0, 0, 0);
    end
    run_op(muldiv_op_pkg::DIV, 32'h8000_0000, 32'hffff_ffff, 0, 0);
    run_op(muldiv_op_pkg::REM, 32'h8000_0000, 32'hffff_ffff, 0, 0);

    // Back-pressure on random operations
    for (k = 0; k < 16; k++) begin
      op = muldiv_op_pkg::op_e'($urandom_range(0, 7));
      b  = $urandom;
      if (b == 32'h0) b = 32'h3;
      run_op(op, $urandom, b, $urandom_range(1, 8),
             (op <= muldiv_op_pkg::MULHU) ? 16 : -1);
    end

    repeat (2) @(posedge clk);
    $display("Errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/muldiv_top.sv
// Multiply/divide unit top level with instances and final result select

`timescale 1ns/10ps

module muldiv_top #(
  parameter int XLEN = muldiv_op_pkg::XLEN_DEFAULT
) (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_req_valid,
  input  muldiv_op_pkg::op_e i_op,
  input  logic [XLEN-1:0]    i_rs1,
  input  logic [XLEN-1:0]    i_rs2,
  output logic               o_req_ready,
  output logic               o_result_valid,
  output logic [XLEN-1:0]    o_result,
  input  logic               i_result_ready
);

  logic                    is_mul;
  logic                    special;
  logic [XLEN-1:0]         special_result;
  muldiv_ctrl_pkg::state_e state;
  logic                    last_step;
  logic                    need_corr;
  logic [XLEN-1:0]         mul_result;
  logic [XLEN-1:0]         div_result;

  muldiv_decode #(.XLEN(XLEN)) u_decode (
    .i_op             (i_op),
    .i_rs1            (i_rs1),
    .i_rs2            (i_rs2),
    .o_is_mul         (is_mul),
    .o_special        (special),
    .o_special_result (special_result)
  );

  muldiv_ctrl #(.XLEN(XLEN)) u_ctrl (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_req_valid    (i_req_valid),
    .i_is_mul       (is_mul),
    .i_special      (special),
    .i_need_corr    (need_corr),
    .i_result_ready (i_result_ready),
    .o_state        (state),
    .o_last_step    (last_step),
    .o_req_ready    (o_req_ready),
    .o_result_valid (o_result_valid)
  );

  booth_mul_dpath #(.XLEN(XLEN)) u_mul (
    .clk (clk), .i_op (i_op), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
    .i_state (state), .i_last_step (last_step), .o_mul_result (mul_result)
  );

  nonrestoring_div_dpath #(.XLEN(XLEN)) u_div (
    .clk (clk), .i_op (i_op), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
    .i_state (state), .i_last_step (last_step),
    .o_div_result (div_result), .o_need_corr (need_corr)
  );

  // Special cases override the divider, otherwise pick by family
  assign o_result = special ? special_result :
                    is_mul  ? mul_result     : div_result;

endmodule

// File: verilog/nonrestoring_div_dpath.sv
// Non-restoring divider datapath with remainder check and result correction

`timescale 1ns/10ps

module nonrestoring_div_dpath #(
  parameter int XLEN = 32
) (
  input  logic                    clk,
  input  muldiv_op_pkg::op_e      i_op,
  input  logic [XLEN-1:0]         i_rs1,
  input  logic [XLEN-1:0]         i_rs2,
  input  muldiv_ctrl_pkg::state_e i_state,
  input  logic                    i_last_step,
  output logic [XLEN-1:0]         o_div_result,
  output logic                    o_need_corr
);

  // Sign-extended operand width and step adder width
  localparam int W = XLEN + 1;
  localparam int A = XLEN + 2;

  logic          is_unsigned;
  logic          rs1_sign;
  logic          rs2_sign;
  logic [A-1:0]  divisor;
  logic          is_idle;
  logic          is_chck;
  logic          step_en;
  logic          quot_init;
  logic          prev_quot;
  logic [A-1:0]  step_op;
  logic [W-1:0]  step_low;
  logic [A-1:0]  step_sum;
  logic          cur_quot;
  logic [W-1:0]  remd_q;
  logic [W-1:0]  quot_q;
  logic          remd_sft1_q;
  logic          remd_is_zero;
  logic          remd_is_divs;
  logic [A-1:0]  remd_plus_divs;
  logic          remd_is_neg_divs;
  logic          inc_quot_dec;
  logic [W-1:0]  quot_corr;
  logic [W-1:0]  remd_corr;
  logic [W-1:0]  remd_out;

  assign is_unsigned = (i_op == muldiv_op_pkg::DIVU) | (i_op == muldiv_op_pkg::REMU);
  assign rs1_sign    = is_unsigned ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign    = is_unsigned ? 1'b0 : i_rs2[XLEN-1];
  assign divisor     = {rs2_sign, rs2_sign, i_rs2};

  assign is_idle = (i_state == muldiv_ctrl_pkg::ST_IDLE);
  assign is_chck = (i_state == muldiv_ctrl_pkg::ST_REMD_CHCK);

  // Step in idle and in every execute cycle
  assign step_en = is_idle | (i_state == muldiv_ctrl_pkg::ST_EXEC);

  ////////////////////////////////////////////////////////////////////////////
  // Iteration step
  ////////////////////////////////////////////////////////////////////////////

  // First quotient digit is -1 when dividend and divisor signs differ
  assign quot_init = ~(rs1_sign ^ rs2_sign);
  assign prev_quot = is_idle ? quot_init : quot_q[0];

  // Idle cycle starts from the shifted dividend
  // Upper half is pure sign, lower half is rs1 with the first digit
  assign step_op  = is_idle ? {A{rs1_sign}} : {remd_sft1_q, remd_q};
  assign step_low = is_idle ? {i_rs1, quot_init} : quot_q;

  // Subtract after a positive digit, add after a negative one
  assign step_sum = prev_quot ? (step_op - divisor) : (step_op + divisor);
  assign cur_quot = ~(step_sum[A-1] ^ rs2_sign);

  always_ff @(posedge clk) begin
    if (step_en) begin
      if (i_last_step) begin
        // Final remainder is kept unshifted, last quotient bit forced to 1
        remd_q <= step_sum[W-1:0];
        quot_q <= {step_low[XLEN-1:0], 1'b1};
      end else begin
        // Shift remainder and quotient left as one long register
        remd_q      <= {step_sum[W-2:0], step_low[W-1]};
        quot_q      <= {step_low[W-2:0], cur_quot};
        remd_sft1_q <= step_sum[W-1];
      end
    end else if (i_state == muldiv_ctrl_pkg::ST_QUOT_CORR) begin
      quot_q <= quot_corr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Remainder check
  ////////////////////////////////////////////////////////////////////////////

  assign remd_is_zero     = ~(|remd_q);
  assign remd_is_divs     = (remd_q == divisor[W-1:0]);
  assign remd_plus_divs   = {remd_q[W-1], remd_q} + divisor;
  assign remd_is_neg_divs = ~(|remd_plus_divs);

  // Wrong sign, or a full divisor left over
  assign o_need_corr = is_chck &
                       (((remd_q[W-1] ^ rs1_sign) & ~remd_is_zero) |
                        remd_is_divs | remd_is_neg_divs);

  ////////////////////////////////////////////////////////////////////////////
  // Correction
  ////////////////////////////////////////////////////////////////////////////

  // Remainder and divisor of opposite sign
  // Quotient goes down one and the remainder gets a divisor back
  assign inc_quot_dec = remd_q[W-1] ^ rs2_sign;

  assign quot_corr = inc_quot_dec ? (quot_q - 1'b1) : (quot_q + 1'b1);
  assign remd_corr = inc_quot_dec ? (remd_q + divisor[W-1:0]) : (remd_q - divisor[W-1:0]);

  // Corrected remainder leaves straight from the adder
  assign remd_out = (i_state == muldiv_ctrl_pkg::ST_REMD_CORR) ? remd_corr : remd_q;

  assign o_div_result = ((i_op == muldiv_op_pkg::DIV) | (i_op == muldiv_op_pkg::DIVU)) ?
                        quot_q[XLEN-1:0] : remd_out[XLEN-1:0];

endmodule

// File: verilog/booth_mul_dpath.sv
// Radix-4 Booth multiplier datapath with partial product registers and result

`timescale 1ns/10ps

module booth_mul_dpath #(
  parameter int XLEN = 32
) (
  input  logic                    clk,
  input  muldiv_op_pkg::op_e      i_op,
  input  logic [XLEN-1:0]         i_rs1,
  input  logic [XLEN-1:0]         i_rs2,
  input  muldiv_ctrl_pkg::state_e i_state,
  input  logic                    i_last_step,
  output logic [XLEN-1:0]         o_mul_result
);

  // Adder covers hi product plus two times the multiplicand
  localparam int ADD_W = XLEN + 3;

  logic             rs1_sign;
  logic             rs2_sign;
  logic             is_idle;
  logic             step_en;
  logic [2:0]       booth_code;
  logic             sel_zero;
  logic             sel_two;
  logic             sel_sub;
  logic [ADD_W-1:0] addend;
  logic [ADD_W-1:0] acc;
  logic [ADD_W-1:0] sum;
  logic [XLEN:0]    prdt_hi_q;
  logic [XLEN:0]    prdt_lo_q;
  logic             prdt_sft1_q;

  // Sign extension by operand kind
  // MULHU is unsigned x unsigned, MULHSU is signed x unsigned
  assign rs1_sign = (i_op == muldiv_op_pkg::MULHU) ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign = ((i_op == muldiv_op_pkg::MULHSU) | (i_op == muldiv_op_pkg::MULHU)) ?
                    1'b0 : i_rs2[XLEN-1];

  assign is_idle = (i_state == muldiv_ctrl_pkg::ST_IDLE);

  // Registers freeze on the final step so the result holds under stall
  assign step_en = is_idle | ((i_state == muldiv_ctrl_pkg::ST_EXEC) & ~i_last_step);

  ////////////////////////////////////////////////////////////////////////////
  // Booth window
  ////////////////////////////////////////////////////////////////////////////

  // First window straight from rs1, last window uses the extended sign
  always_comb begin
    if (is_idle) begin
      booth_code = {i_rs1[1:0], 1'b0};
    end else if (i_last_step) begin
      booth_code = {rs1_sign, prdt_lo_q[0], prdt_sft1_q};
    end else begin
      booth_code = {prdt_lo_q[1:0], prdt_sft1_q};
    end
  end

  // 000/111 give 0, 011/100 give 2, rest 1; top bit negates
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);
  assign sel_sub  = booth_code[2];

  always_comb begin
    if (sel_zero) begin
      addend = '0;
    end else if (sel_two) begin
      addend = {rs2_sign, rs2_sign, i_rs2, 1'b0};
    end else begin
      addend = {rs2_sign, rs2_sign, rs2_sign, i_rs2};
    end
  end

  // Running high partial product, cleared on the first step
  assign acc = is_idle ? {ADD_W{1'b0}} : {prdt_hi_q[XLEN], prdt_hi_q[XLEN], prdt_hi_q};
  assign sum = sel_sub ? (acc - addend) : (acc + addend);

  // Two product bits shift into the low register per step
  always_ff @(posedge clk) begin
    if (step_en) begin
      prdt_hi_q   <= sum[ADD_W-1:2];
      prdt_lo_q   <= {sum[1:0], (is_idle ? {rs1_sign, i_rs1[XLEN-1:2]} : prdt_lo_q[XLEN:2])};
      prdt_sft1_q <= is_idle ? i_rs1[1] : prdt_lo_q[1];
    end
  end

  // Low word sits in the shift register, high word comes off the adder
  assign o_mul_result = (i_op == muldiv_op_pkg::MUL) ? prdt_lo_q[XLEN:1] : sum[XLEN-1:0];

endmodule

// File: verilog/muldiv_ctrl.sv
// Sequencer FSM, step counter and coupled request/result handshake

`timescale 1ns/10ps

module muldiv_ctrl #(
  parameter int XLEN = 32
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_req_valid,
  input  logic                    i_is_mul,
  input  logic                    i_special,
  input  logic                    i_need_corr,
  input  logic                    i_result_ready,
  output muldiv_ctrl_pkg::state_e o_state,
  output logic                    o_last_step,
  output logic                    o_req_ready,
  output logic                    o_result_valid
);

  localparam int CNT_W = muldiv_ctrl_pkg::CNT_W;

  // Last step count for each family
  localparam logic [CNT_W-1:0] MUL_LAST  = CNT_W'(XLEN / 2);
  localparam logic [CNT_W-1:0] DIV_LAST  = CNT_W'(XLEN);
  localparam logic [CNT_W-1:0] CNT_START = CNT_W'(muldiv_ctrl_pkg::CNT_START);

  muldiv_ctrl_pkg::state_e state_q;
  muldiv_ctrl_pkg::state_e state_d;
  logic [CNT_W-1:0]        cnt_q;
  logic [CNT_W-1:0]        cnt_d;
  logic                    done;
  logic                    retire;

  assign o_state = state_q;

  // Last execute cycle depends on the family
  assign o_last_step = (state_q == muldiv_ctrl_pkg::ST_EXEC) &
                       (cnt_q == (i_is_mul ? MUL_LAST : DIV_LAST));

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Result complete
  // Special cases finish in the idle cycle, divides wait for the check
  always_comb begin
    case (state_q)
      muldiv_ctrl_pkg::ST_IDLE:      done = i_special;
      muldiv_ctrl_pkg::ST_EXEC:      done = o_last_step & i_is_mul;
      muldiv_ctrl_pkg::ST_REMD_CHCK: done = ~i_need_corr;
      muldiv_ctrl_pkg::ST_REMD_CORR: done = 1'b1;
      default:                       done = 1'b0;
    endcase
  end

  // Request and result retire together
  assign o_result_valid = done & i_req_valid;
  assign o_req_ready    = done & i_result_ready;
  assign retire         = o_result_valid & i_result_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      muldiv_ctrl_pkg::ST_IDLE: begin
        // Special cases never leave idle
        if (i_req_valid & ~i_special) begin
          state_d = muldiv_ctrl_pkg::ST_EXEC;
          cnt_d   = CNT_START;
        end
      end
      muldiv_ctrl_pkg::ST_EXEC: begin
        if (~o_last_step) begin
          cnt_d = cnt_q + 1'b1;
        end else if (~i_is_mul) begin
          state_d = muldiv_ctrl_pkg::ST_REMD_CHCK;
        end else if (retire) begin
          state_d = muldiv_ctrl_pkg::ST_IDLE;
        end
      end
      muldiv_ctrl_pkg::ST_REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = muldiv_ctrl_pkg::ST_QUOT_CORR;
        end else if (retire) begin
          state_d = muldiv_ctrl_pkg::ST_IDLE;
        end
      end
      // Quotient fix always takes one cycle
      muldiv_ctrl_pkg::ST_QUOT_CORR: state_d = muldiv_ctrl_pkg::ST_REMD_CORR;
      muldiv_ctrl_pkg::ST_REMD_CORR: begin
        if (retire) begin
          state_d = muldiv_ctrl_pkg::ST_IDLE;
        end
      end
      default: state_d = muldiv_ctrl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= muldiv_ctrl_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// File: verilog/muldiv_decode.sv
// Operation class decode and divide special-case detection with fixed results

`timescale 1ns/10ps

module muldiv_decode #(
  parameter int XLEN = 32
) (
  input  muldiv_op_pkg::op_e i_op,
  input  logic [XLEN-1:0]    i_rs1,
  input  logic [XLEN-1:0]    i_rs2,
  output logic               o_is_mul,
  output logic               o_special,
  output logic [XLEN-1:0]    o_special_result
);

  logic is_quot;
  logic is_signed_div;
  logic div_by_zero;
  logic div_ovf;

  // Multiply group is the lower half of the encoding
  assign o_is_mul = (i_op == muldiv_op_pkg::MUL)    |
                    (i_op == muldiv_op_pkg::MULH)   |
                    (i_op == muldiv_op_pkg::MULHSU) |
                    (i_op == muldiv_op_pkg::MULHU);

  // Quotient or remainder wanted
  assign is_quot = (i_op == muldiv_op_pkg::DIV) | (i_op == muldiv_op_pkg::DIVU);

  // Only signed divides can overflow
  assign is_signed_div = (i_op == muldiv_op_pkg::DIV) | (i_op == muldiv_op_pkg::REM);

  // Divisor all zeros
  assign div_by_zero = ~(|i_rs2);

  // Most negative dividend over minus one
  assign div_ovf = is_signed_div & (&i_rs2) &
                   i_rs1[XLEN-1] & ~(|i_rs1[XLEN-2:0]);

  // Divides that bypass the iterative engine
  assign o_special = ~o_is_mul & (div_by_zero | div_ovf);

  ////////////////////////////////////////////////////////////////////////////
  // Fixed results per RISC-V M rules
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (div_by_zero) begin
      // Quotient all ones, remainder is the dividend
      o_special_result = is_quot ? {XLEN{1'b1}} : i_rs1;
    end else begin
      // Overflow: quotient is the dividend, remainder zero
      o_special_result = is_quot ? i_rs1 : {XLEN{1'b0}};
    end
  end

endmodule

// File: verilog/muldiv_ctrl_pkg.sv
// Controller state encoding and step counter constants

package muldiv_ctrl_pkg;

  // Width of the state register
  localparam int STATE_W = 3;

  // Step counter, wide enough to reach XLEN for a 32-bit core
  localparam int CNT_W = 6;

  // Value loaded on entry to the execute state
  // The first cycle in idle already counts as step 0
  localparam int CNT_START = 1;

  // Sequencer states
  typedef enum logic [STATE_W-1:0] {
    ST_IDLE      = 3'd0,  // first cycle, operands seen
    ST_EXEC      = 3'd1,  // iterating
    ST_REMD_CHCK = 3'd2,  // divide result check
    ST_QUOT_CORR = 3'd3,  // quotient correction
    ST_REMD_CORR = 3'd4   // remainder correction
  } state_e;

endpackage

// File: verilog/muldiv_op_pkg.sv
// Operation encoding and data width constants for the multiply/divide unit

package muldiv_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  // Operand and result width of the integer core
  localparam int XLEN_DEFAULT = 32;

  // Width of the opcode field
  localparam int OP_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // M-extension operations
  ////////////////////////////////////////////////////////////////////////////

  // Multiply group first, divide group after
  typedef enum logic [OP_W-1:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } op_e;

endpackage
